// ==== verilog/bus_pkg.sv ====
package bus_pkg;

	localparam int ADDR_W = 8;
	localparam int DATA_W = 16;
	localparam int REGION_W = 2;
	localparam int OFFSET_W = ADDR_W - REGION_W;

	localparam int NUM_MASTERS = 2;
	localparam int NUM_SLAVES = 3;

	// master port fifo, also the credits a master owns out of reset
	localparam int PORT_DEPTH = 2;
	localparam int PTR_W = $clog2(PORT_DEPTH);
	localparam int CNT_W = $clog2(PORT_DEPTH + 1);

	// credits held per slave in the switch
	localparam int SLAVE_CREDITS = 2;
	localparam int CREDIT_W = $clog2(SLAVE_CREDITS + 1);

	localparam logic [REGION_W-1:0] REGION_UNMAPPED = 2'd3; // no slave behind it

	typedef struct packed {
		logic [REGION_W-1:0] region; // picks the slave
		logic [OFFSET_W-1:0] offset;
	} addr_fields_t;

	// slaves see a flat address, the decoder looks at the fields
	typedef union packed {
		logic [ADDR_W-1:0] addr;
		addr_fields_t fields;
	} bus_addr_u;

	typedef struct packed {
		logic write;
		bus_addr_u addr;
		logic [DATA_W-1:0] wdata;
	} bus_cmd_t;

	typedef struct packed {
		bus_cmd_t cmd;
		logic master_id; // which master sent it
	} slave_cmd_t;

endpackage

// ==== verilog/master_port.sv ====
module master_port (
	input  logic              sys_clk,
	input  logic              arst_n,
	input  bus_pkg::bus_cmd_t cmd,
	input  logic              cmd_valid,
	output logic              credit,
	output bus_pkg::bus_cmd_t head,
	output logic              head_valid,
	input  logic              pop
);

	bus_pkg::bus_cmd_t mem [bus_pkg::PORT_DEPTH];

	logic [bus_pkg::PTR_W-1:0] wr_ptr;
	logic [bus_pkg::PTR_W-1:0] rd_ptr;
	logic [bus_pkg::CNT_W-1:0] count;
	logic full;
	logic empty;

	assign full = (count == bus_pkg::CNT_W'(bus_pkg::PORT_DEPTH));
	assign empty = (count == '0);

	assign head = mem[rd_ptr];
	assign head_valid = !empty;

	// fifo storage
	always_ff @(posedge sys_clk) begin
		if (cmd_valid) begin
			mem[wr_ptr] <= cmd;
		end
	end

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (cmd_valid) begin
				wr_ptr <= wr_ptr + 1'b1; // wraps at depth 2
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// occupancy
	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			count <= '0;
		end else begin
			case ({cmd_valid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// credit goes back one cycle after the head leaves
	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			credit <= 1'b0;
		end else begin
			credit <= pop;
		end
	end

	// master spent a credit it did not have
	a_no_overflow: assert property (@(posedge sys_clk) disable iff (!arst_n)
		cmd_valid |-> !full)
		else $error("master_port: command received while fifo full");

	// switch took a head that was not there
	a_no_underflow: assert property (@(posedge sys_clk) disable iff (!arst_n)
		pop |-> !empty)
		else $error("master_port: pop while fifo empty");

endmodule

// ==== verilog/interconnect_switch.sv ====
module interconnect_switch (
	input  logic                                          sys_clk,
	input  logic                                          arst_n,
	input  bus_pkg::bus_cmd_t [bus_pkg::NUM_MASTERS-1:0]  head,
	input  logic [bus_pkg::NUM_MASTERS-1:0]               head_valid,
	output logic [bus_pkg::NUM_MASTERS-1:0]               pop,
	output bus_pkg::slave_cmd_t [bus_pkg::NUM_SLAVES-1:0] s_cmd,
	output logic [bus_pkg::NUM_SLAVES-1:0]                s_cmd_valid,
	input  logic [bus_pkg::NUM_SLAVES-1:0]                s_credit,
	output logic [bus_pkg::NUM_MASTERS-1:0]               unmapped
);

	logic [bus_pkg::CREDIT_W-1:0] credit_cnt [bus_pkg::NUM_SLAVES];
	logic [bus_pkg::NUM_SLAVES-1:0] has_credit;

	logic [bus_pkg::NUM_MASTERS-1:0][bus_pkg::NUM_SLAVES-1:0] target; // one-hot or zero
	logic [bus_pkg::NUM_MASTERS-1:0] mapped;
	logic [bus_pkg::NUM_MASTERS-1:0] eligible;

	logic last_winner;
	logic win_id;
	bus_pkg::bus_cmd_t win_cmd;
	logic [bus_pkg::NUM_SLAVES-1:0] send;

	// region decode per head
	always_comb begin
		for (int i = 0; i < bus_pkg::NUM_MASTERS; i++) begin
			mapped[i] = (head[i].addr.fields.region != bus_pkg::REGION_UNMAPPED);
			target[i] = '0;
			for (int j = 0; j < bus_pkg::NUM_SLAVES; j++) begin
				if (head[i].addr.fields.region == bus_pkg::REGION_W'(j)) begin
					target[i][j] = 1'b1;
				end
			end
		end
	end

	always_comb begin
		for (int j = 0; j < bus_pkg::NUM_SLAVES; j++) begin
			has_credit[j] = (credit_cnt[j] != '0);
		end
	end

	// unmapped heads never wait on a slave
	always_comb begin
		for (int i = 0; i < bus_pkg::NUM_MASTERS; i++) begin
			eligible[i] = head_valid[i] && (!mapped[i] || |(target[i] & has_credit));
		end
	end

	// loser of the last grant goes first
	always_comb begin
		pop = '0;
		if (eligible[~last_winner]) begin
			pop[~last_winner] = 1'b1;
		end else if (eligible[last_winner]) begin
			pop[last_winner] = 1'b1;
		end
	end

	assign win_id = pop[1];
	assign win_cmd = head[win_id];
	assign send = (|pop) ? target[win_id] : '0;

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			s_cmd_valid <= '0;
			unmapped <= '0;
			last_winner <= 1'b1; // master 0 first out of reset
		end else begin
			s_cmd_valid <= send;
			unmapped <= pop & ~mapped;
			if (|pop) begin
				last_winner <= win_id;
			end
		end
	end

	// payload tagged with the source master
	always_ff @(posedge sys_clk) begin
		for (int j = 0; j < bus_pkg::NUM_SLAVES; j++) begin
			if (send[j]) begin
				s_cmd[j].cmd <= win_cmd;
				s_cmd[j].master_id <= win_id;
			end
		end
	end

	// send and return may land together
	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int j = 0; j < bus_pkg::NUM_SLAVES; j++) begin
				credit_cnt[j] <= bus_pkg::CREDIT_W'(bus_pkg::SLAVE_CREDITS);
			end
		end else begin
			for (int j = 0; j < bus_pkg::NUM_SLAVES; j++) begin
				case ({s_credit[j], send[j]})
					2'b10: credit_cnt[j] <= credit_cnt[j] + 1'b1;
					2'b01: credit_cnt[j] <= credit_cnt[j] - 1'b1;
					default: credit_cnt[j] <= credit_cnt[j];
				endcase
			end
		end
	end

	// a slave handing back more than it was given
	for (genvar j = 0; j < bus_pkg::NUM_SLAVES; j++) begin : g_credit_chk
		a_credit_max: assert property (@(posedge sys_clk) disable iff (!arst_n)
			credit_cnt[j] <= bus_pkg::CREDIT_W'(bus_pkg::SLAVE_CREDITS))
			else $error("switch: slave %0d credit count above limit", j);
	end

endmodule

// ==== verilog/bus_interconnect.sv ====
module bus_interconnect (
	input  logic                                          sys_clk,
	input  logic                                          arst_n,
	input  bus_pkg::bus_cmd_t [bus_pkg::NUM_MASTERS-1:0]  m_cmd,
	input  logic [bus_pkg::NUM_MASTERS-1:0]               m_cmd_valid,
	output logic [bus_pkg::NUM_MASTERS-1:0]               m_credit,
	output logic [bus_pkg::NUM_MASTERS-1:0]               m_unmapped,
	output bus_pkg::slave_cmd_t [bus_pkg::NUM_SLAVES-1:0] s_cmd,
	output logic [bus_pkg::NUM_SLAVES-1:0]                s_cmd_valid,
	input  logic [bus_pkg::NUM_SLAVES-1:0]                s_credit
);

	// port heads toward the switch
	bus_pkg::bus_cmd_t [bus_pkg::NUM_MASTERS-1:0] head;
	logic [bus_pkg::NUM_MASTERS-1:0] head_valid;
	logic [bus_pkg::NUM_MASTERS-1:0] pop;

	master_port master_port_0 (
		.sys_clk    (sys_clk),
		.arst_n     (arst_n),
		.cmd        (m_cmd[0]),
		.cmd_valid  (m_cmd_valid[0]),
		.credit     (m_credit[0]),
		.head       (head[0]),
		.head_valid (head_valid[0]),
		.pop        (pop[0])
	);

	master_port master_port_1 (
		.sys_clk    (sys_clk),
		.arst_n     (arst_n),
		.cmd        (m_cmd[1]),
		.cmd_valid  (m_cmd_valid[1]),
		.credit     (m_credit[1]),
		.head       (head[1]),
		.head_valid (head_valid[1]),
		.pop        (pop[1])
	);

	interconnect_switch interconnect_switch_inst (
		.sys_clk     (sys_clk),
		.arst_n      (arst_n),
		.head        (head),
		.head_valid  (head_valid),
		.pop         (pop),
		.s_cmd       (s_cmd),
		.s_cmd_valid (s_cmd_valid),
		.s_credit    (s_credit),
		.unmapped    (m_unmapped)  // region 3 flag back to the master
	);

endmodule

// ==== dv/bus_interconnect_tb.sv ====
module bus_interconnect_tb;

	localparam int DRAIN_TIMEOUT = 3000; // cycles

	logic sys_clk;
	logic arst_n;
	bus_pkg::bus_cmd_t [bus_pkg::NUM_MASTERS-1:0] m_cmd;
	logic [bus_pkg::NUM_MASTERS-1:0] m_cmd_valid;
	logic [bus_pkg::NUM_MASTERS-1:0] m_credit;
	logic [bus_pkg::NUM_MASTERS-1:0] m_unmapped;
	bus_pkg::slave_cmd_t [bus_pkg::NUM_SLAVES-1:0] s_cmd;
	logic [bus_pkg::NUM_SLAVES-1:0] s_credit;
	logic [bus_pkg::NUM_SLAVES-1:0] s_cmd_valid;

	bus_pkg::bus_cmd_t stim_q [bus_pkg::NUM_MASTERS][$];
	bus_pkg::slave_cmd_t exp_q [bus_pkg::NUM_SLAVES * bus_pkg::NUM_MASTERS][$]; // slave*2 + master
	int due_q [bus_pkg::NUM_SLAVES][$]; // cycle at which each slave credit goes back

	int idx [bus_pkg::NUM_MASTERS];
	int credits [bus_pkg::NUM_MASTERS];
	int credits_back [bus_pkg::NUM_MASTERS];
	int issued [bus_pkg::NUM_MASTERS];
	int delivered [bus_pkg::NUM_MASTERS];
	int exp_unmapped [bus_pkg::NUM_MASTERS];
	int unmapped_seen [bus_pkg::NUM_MASTERS];
	int outstanding [bus_pkg::NUM_SLAVES];
	int cyc_cnt;
	int k_idx;
	int due;
	int wait_cyc;
	logic running;
	logic mid_bit;

	bus_interconnect bus_interconnect_inst (
		.sys_clk     (sys_clk),
		.arst_n      (arst_n),
		.m_cmd       (m_cmd),
		.m_cmd_valid (m_cmd_valid),
		.m_credit    (m_credit),
		.m_unmapped  (m_unmapped),
		.s_cmd       (s_cmd),
		.s_cmd_valid (s_cmd_valid),
		.s_credit    (s_credit)
	);

	always #2 sys_clk = ~sys_clk;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_cmd(input string name, input bus_pkg::slave_cmd_t exp,
			input bus_pkg::slave_cmd_t act);
		if (exp !== act) begin
			fail_run($sformatf("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act));
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (exp != act) begin
			fail_run($sformatf("Mismatch at %0t: %s expected %0d, got %0d", $time, name, exp, act));
		end
	endtask

	// expected queues follow straight from the address region
	task automatic load_vectors();
		int fd;
		int rc;
		int n;
		int mid;
		int wr;
		logic [bus_pkg::ADDR_W-1:0] addr_v;
		logic [bus_pkg::DATA_W-1:0] data_v;
		logic [1:0] region;
		string line;
		bus_pkg::bus_cmd_t cmd;
		bus_pkg::slave_cmd_t sc;
		fd = $fopen("dv/bus_vectors.txt", "r");
		if (fd == 0) begin
			fail_run("could not open dv/bus_vectors.txt for reading");
		end
		while (!$feof(fd)) begin
			line = "";
			rc = $fgets(line, fd);
			if (rc == 0 || line.len() == 0 || line[0] == "#") begin
				continue;
			end
			n = $sscanf(line, "%d %d %h %h", mid, wr, addr_v, data_v);
			if (n != 4) begin
				continue;
			end
			cmd.write = wr[0];
			cmd.addr.addr = addr_v;
			cmd.wdata = data_v;
			stim_q[mid].push_back(cmd);
			region = addr_v[7:6];
			if (region == 2'd3) begin
				exp_unmapped[mid]++;
			end else begin
				sc.cmd = cmd;
				sc.master_id = mid[0];
				exp_q[region * 2 + mid].push_back(sc);
			end
		end
		$fclose(fd);
	endtask

	function automatic bit all_drained();
		bit done;
		done = 1'b1;
		for (int i = 0; i < bus_pkg::NUM_MASTERS; i++) begin
			if (idx[i] != stim_q[i].size() || delivered[i] != issued[i]
					|| credits[i] != bus_pkg::PORT_DEPTH) begin
				done = 1'b0;
			end
		end
		for (int j = 0; j < bus_pkg::NUM_SLAVES; j++) begin
			if (due_q[j].size() != 0) begin
				done = 1'b0;
			end
		end
		return done;
	endfunction

	// slave and master models sampled on the rising edge
	always @(posedge sys_clk) begin
		if (running) begin
			cyc_cnt++;
			for (int j = 0; j < bus_pkg::NUM_SLAVES; j++) begin
				if (s_cmd_valid[j]) begin
					mid_bit = s_cmd[j].master_id;
					k_idx = j * 2 + mid_bit;
					delivered[mid_bit]++;
					outstanding[j]++;
					if (outstanding[j] > bus_pkg::SLAVE_CREDITS) begin
						fail_run($sformatf("slave %0d holds more commands than its credits", j));
					end
					if (exp_q[k_idx].size() == 0) begin
						fail_run($sformatf("slave %0d got a command from master %0d that was not expected",
							j, mid_bit));
					end else begin
						check_cmd($sformatf("s_cmd[%0d]", j), exp_q[k_idx].pop_front(), s_cmd[j]);
					end
					due = cyc_cnt + $urandom_range(0, 5);
					if (due_q[j].size() > 0 && due <= due_q[j][$]) begin
						due = due_q[j][$] + 1; // one pulse per cycle
					end
					due_q[j].push_back(due);
				end
				if (due_q[j].size() > 0 && due_q[j][0] <= cyc_cnt) begin
					void'(due_q[j].pop_front());
					s_credit[j] <= 1'b1;
					outstanding[j]--;
				end else begin
					s_credit[j] <= 1'b0;
				end
			end
			for (int i = 0; i < bus_pkg::NUM_MASTERS; i++) begin
				if (m_credit[i]) begin
					credits[i]++;
					credits_back[i]++;
					if (credits[i] > bus_pkg::PORT_DEPTH) begin
						fail_run($sformatf("master %0d got back more credits than it spent", i));
					end
				end
				if (m_unmapped[i]) begin
					unmapped_seen[i]++;
					delivered[i]++;
				end
				if (issued[i] - delivered[i] > bus_pkg::PORT_DEPTH + bus_pkg::SLAVE_CREDITS) begin
					fail_run($sformatf("master %0d fell behind, %0d issued and %0d delivered",
						i, issued[i], delivered[i]));
				end
				if (idx[i] < stim_q[i].size() && credits[i] > 0 && $urandom_range(0, 3) != 0) begin
					m_cmd[i] <= stim_q[i][idx[i]];
					m_cmd_valid[i] <= 1'b1;
					idx[i]++;
					credits[i]--;
					issued[i]++;
				end else begin
					m_cmd_valid[i] <= 1'b0;
				end
			end
		end
	end

	initial begin
		void'($urandom(73));
		sys_clk = 1'b0;
		arst_n = 1'b0;
		m_cmd = '0;
		m_cmd_valid = '0;
		s_credit = '0;
		running = 1'b0;
		cyc_cnt = 0;
		for (int i = 0; i < bus_pkg::NUM_MASTERS; i++) begin
			idx[i] = 0;
			credits[i] = bus_pkg::PORT_DEPTH;
			credits_back[i] = 0;
			issued[i] = 0;
			delivered[i] = 0;
			exp_unmapped[i] = 0;
			unmapped_seen[i] = 0;
		end
		for (int j = 0; j < bus_pkg::NUM_SLAVES; j++) begin
			outstanding[j] = 0;
		end
		load_vectors();
		repeat (8) @(posedge sys_clk);
		arst_n <= 1'b1;
		// quiet outputs before any traffic
		repeat (4) begin
			@(posedge sys_clk);
			check_count("s_cmd_valid", 0, int'(s_cmd_valid));
			check_count("m_credit", 0, int'(m_credit));
			check_count("m_unmapped", 0, int'(m_unmapped));
		end
		running <= 1'b1;
		@(posedge sys_clk);
		wait_cyc = 0;
		while (!all_drained() && wait_cyc < DRAIN_TIMEOUT) begin
			@(posedge sys_clk);
			wait_cyc++;
		end
		if (!all_drained()) begin
			fail_run("timed out waiting for all commands to reach the slaves");
		end
		for (int i = 0; i < bus_pkg::NUM_MASTERS; i++) begin
			check_count($sformatf("m_credit[%0d] tally", i), issued[i], credits_back[i]);
			check_count($sformatf("m_unmapped[%0d] tally", i), exp_unmapped[i], unmapped_seen[i]);
		end
		for (int k = 0; k < bus_pkg::NUM_SLAVES * bus_pkg::NUM_MASTERS; k++) begin
			check_count($sformatf("undelivered commands slave %0d master %0d", k / 2, k % 2),
				0, exp_q[k].size());
		end
		$display("STATUS: PASS");
		$finish;
	end

endmodule

// ==== build.f ====
verilog/bus_pkg.sv
verilog/master_port.sv
verilog/interconnect_switch.sv
verilog/bus_interconnect.sv
dv/bus_interconnect_tb.sv

// ==== dv/bus_vectors.txt ====
# columns: master id, write flag, address (hex), write data (hex)
# address bits 7:6 pick slave 0..2, region 3 (c0..ff) is unmapped
0 1 05 1a01
0 1 07 1a02
0 0 10 0000
0 1 45 1a03
0 1 46 1a04
0 0 47 0000
0 1 48 1a05
0 1 c1 dead
0 1 09 1a06
0 0 82 0000
0 1 83 1a07
0 1 84 1a08
0 1 49 1a09
0 1 4a 1a0a
0 0 f0 0000
0 1 3f 1a0b
0 1 85 1a0c
0 1 4b 1a0d
0 1 4c 1a0e
0 1 0a 1a0f
1 1 50 2b01
1 1 51 2b02
1 0 52 0000
1 1 53 2b03
1 1 90 2b04
1 1 91 2b05
1 0 c8 0000
1 1 20 2b06
1 1 92 2b07
1 1 54 2b08
1 1 55 2b09
1 0 a0 0000
1 1 21 2b0a
1 1 ff beef
1 1 56 2b0b
1 1 93 2b0c
1 1 22 2b0d
1 0 57 0000
1 1 94 2b0e
1 1 58 2b0f
